// ==== sources.f ====
rtl/bridge_pkg.sv
rtl/write_capture.sv
rtl/beat_sequencer.sv
rtl/resp_capture.sv
rtl/bridge_ctrl.sv
rtl/axi_ahb_bridge.sv
test/tb_ahb_memory.sv
test/tb_axi_ahb_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_ahb_bridge
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f sources.f
	-$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_axi_ahb_bridge.sv ====
// AXI to AHB bridge testbench

`timescale 1ns/1ps

module tb_axi_ahb_bridge
   import bridge_pkg::*;
();

   localparam int    ID_WIDTH       = 4;
   localparam addr_t ERR_ADDR       = 32'h0000_0f00;
   localparam int    NUM_ROWS       = 18;
   localparam int    TIMEOUT_CYCLES = NUM_ROWS * 200;

   typedef enum logic [1:0] {OP_WRITE, OP_WRITE_W_FIRST, OP_READ} op_t;

   typedef struct {
      op_t                 op;
      logic [ID_WIDTH-1:0] id;
      addr_t               addr;
      ahb_size_t           size;
      data_t               data;
      strb_t               strb;
      axi_resp_t           resp;
      int                  beats;   // Expected AHB write beats
      int                  hold;    // Cycles with bready or rready held low
   } txn_t;

   logic bus_clk = 1'b0;
   logic reset;
   logic awvalid, awready, wvalid, wready, wlast, arvalid, arready;
   logic bvalid, bready, rvalid, rready, rlast, hwrite, hready, hresp;
   logic [ID_WIDTH-1:0] awid, arid, bid, rid;
   addr_t      awaddr, araddr, haddr;
   ahb_size_t  awsize, arsize, hsize;
   data_t      wdata, rdata, hwdata, hrdata;
   strb_t      wstrb;
   axi_resp_t  bresp, rresp;
   ahb_trans_t htrans;

   txn_t      rows [NUM_ROWS];
   data_t     shadow [addr_t];   // Expected memory words
   addr_t     beat_addr [0:7];
   ahb_size_t beat_size [0:7];
   int        cycle_count = 0;

   axi_ahb_bridge #(.ID_WIDTH(ID_WIDTH)) axi_ahb_bridge_inst (.*);

   tb_ahb_memory #(.ERR_ADDR(ERR_ADDR), .SEED(32'h590d_0229)) memory_inst (.*);

   always #10 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         fail_now($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   //**************************************************************************
   // Reporting and checks
   //**************************************************************************

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0d ns: %s resp %0d, expected %0d",
                            $time, what, got, exp));
   endtask

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0d ns: %s data %h, expected %h",
                            $time, what, got, exp));
   endtask

   task automatic check_beat(input addr_t got_addr, input ahb_size_t got_size,
                             input addr_t exp_addr, input ahb_size_t exp_size,
                             input string what);
      if (got_addr !== exp_addr || got_size !== exp_size)
         fail_now($sformatf("CHECK FAILED at %0d ns: %s beat %h size %0d, expected %h size %0d",
                            $time, what, got_addr, got_size, exp_addr, exp_size));
   endtask

   task automatic check_id(input logic [ID_WIDTH-1:0] got, input logic [ID_WIDTH-1:0] exp,
                           input string what);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0d ns: %s id %0d, expected %0d",
                            $time, what, got, exp));
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
         fail_now($sformatf("CHECK FAILED at %0d ns: %s %0d beats, expected %0d",
                            $time, what, got, exp));
   endtask

   //**************************************************************************
   // Expected results
   //**************************************************************************

   function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
      data_t result;
      result = old_word;
      for (int i = 0; i < 8; i++) begin
         if (strb[i])
            result[i*8 +: 8] = new_word[i*8 +: 8];
      end
      return result;
   endfunction

   // Beats for a full width write; a naturally aligned run of 2, 4 or 8 bytes goes out whole
   task automatic derive_beats(input addr_t addr, input strb_t strb, output int n);
      int count;
      int low;
      count = $countones(strb);
      low   = 8;
      n     = 0;
      for (int i = 7; i >= 0; i--) begin
         if (strb[i])
            low = i;
      end
      if (count inside {2, 4, 8} && low % count == 0 &&
          strb == strb_t'(((1 << count) - 1) << low)) begin
         beat_addr[0] = {addr[31:3], 3'(low)};
         beat_size[0] = ahb_size_t'($clog2(count));
         n = 1;
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
               beat_addr[n] = {addr[31:3], 3'(i)};   // One byte per set lane
               beat_size[n] = 3'd0;
               n++;
            end
         end
      end
   endtask

   //**************************************************************************
   // AXI driver
   //**************************************************************************

   task automatic send_write(input txn_t t);
      logic aw_done;
      logic w_done;
      logic aw_go;
      logic w_go;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(negedge bus_clk);
      wvalid  = 1'b1;
      wdata   = t.data;
      wstrb   = t.strb;
      awid    = t.id;
      awaddr  = t.addr;
      awsize  = t.size;
      awvalid = (t.op == OP_WRITE);   // Address follows the data otherwise
      while (!(aw_done && w_done)) begin
         #1;
         aw_go = awvalid & awready;
         w_go  = wvalid & wready;
         @(negedge bus_clk);
         if (aw_go) begin
            awvalid = 1'b0;
            aw_done = 1'b1;
         end
         if (w_go) begin
            wvalid = 1'b0;
            w_done = 1'b1;
         end
         if (w_done && !aw_done)
            awvalid = 1'b1;
      end
   endtask

   task automatic send_read(input txn_t t);
      logic ar_go;
      ar_go = 1'b0;
      @(negedge bus_clk);
      arvalid = 1'b1;
      arid    = t.id;
      araddr  = t.addr;
      arsize  = t.size;
      while (!ar_go) begin
         #1;
         ar_go = arready;
         @(negedge bus_clk);
      end
      arvalid = 1'b0;
   endtask

   task automatic wait_response(input txn_t t, output axi_resp_t resp, output data_t data);
      logic is_read;
      is_read = (t.op == OP_READ);
      #1;
      while (!(is_read ? rvalid : bvalid)) begin
         @(negedge bus_clk);
         #1;
      end
      for (int i = 0; i <= t.hold; i++) begin
         if (i > 0) begin
            @(negedge bus_clk);
            #1;
         end
         if (!(is_read ? rvalid : bvalid))
            fail_now("Response valid dropped while ready was still low");
         if (arready)
            fail_now("arready went high while a response was pending");
         if (is_read && rlast !== 1'b1)
            fail_now($sformatf("CHECK FAILED at %0d ns: rlast low on a read response", $time));
         check_id(is_read ? rid : bid, t.id, "response");
      end
      resp = is_read ? rresp : bresp;
      data = rdata;
      @(negedge bus_clk);
      if (is_read)
         rready = 1'b1;
      else
         bready = 1'b1;
      @(negedge bus_clk);
      rready = 1'b0;
      bready = 1'b0;
   endtask

   function automatic txn_t make_txn(op_t op, int id, addr_t addr, data_t data, strb_t strb,
                                     axi_resp_t resp, int beats, int hold);
      txn_t t;
      t.op    = op;
      t.id    = ID_WIDTH'(id);
      t.addr  = addr;
      t.size  = 3'd3;   // Full bus width
      t.data  = data;
      t.strb  = strb;
      t.resp  = resp;
      t.beats = beats;
      t.hold  = hold;
      return t;
   endfunction

   //**************************************************************************
   // Transaction table and main loop
   //**************************************************************************

   initial begin
      txn_t      t;
      axi_resp_t resp;
      data_t     data;
      data_t     expected;
      int        n_beats;
      int        log_start;
      string     tag;
      addr_t     last_beat_addr;
      {awvalid, wvalid, arvalid, bready, rready} = '0;
      {awid, arid, awaddr, araddr, awsize, arsize, wdata, wstrb} = '0;
      wlast          = 1'b1;   // Single beat bursts
      reset          = 1'b1;
      last_beat_addr = '0;
      rows[0]  = make_txn(OP_WRITE, 1, 32'h100, 64'h0123_4567_89ab_cdef, 8'hff, RESP_OKAY, 1, 0);
      rows[1]  = make_txn(OP_READ, 2, 32'h100, '0, 8'h00, RESP_OKAY, 0, 0);
      rows[2]  = make_txn(OP_WRITE, 3, 32'h100, 64'h1111_2222_3333_4444, 8'h0f, RESP_OKAY, 1, 0);
      rows[3]  = make_txn(OP_WRITE, 4, 32'h100, 64'h5555_6666_7777_8888, 8'hf0, RESP_OKAY, 1, 0);
      rows[4]  = make_txn(OP_WRITE, 5, 32'h100, 64'h9999_aaaa_bbbb_cccc, 8'h03, RESP_OKAY, 1, 0);
      rows[5]  = make_txn(OP_WRITE, 6, 32'h100, 64'hdddd_eeee_ffff_0000, 8'h0c, RESP_OKAY, 1, 0);
      rows[6]  = make_txn(OP_WRITE, 7, 32'h100, 64'h1357_9bdf_2468_ace0, 8'h30, RESP_OKAY, 1, 0);
      rows[7]  = make_txn(OP_WRITE, 8, 32'h100, 64'hfedc_ba98_7654_3210, 8'hc0, RESP_OKAY, 1, 0);
      rows[8]  = make_txn(OP_READ, 9, 32'h100, '0, 8'h00, RESP_OKAY, 0, 0);
      rows[9]  = make_txn(OP_WRITE, 10, 32'h108, 64'ha5a5_5a5a_c3c3_3c3c, 8'hff, RESP_OKAY, 1, 0);
      rows[10] = make_txn(OP_WRITE, 11, 32'h108, 64'h0f1e_2d3c_4b5a_6978, 8'h5a, RESP_OKAY, 4, 0);
      rows[11] = make_txn(OP_READ, 12, 32'h108, '0, 8'h00, RESP_OKAY, 0, 0);
      rows[12] = make_txn(OP_READ, 13, ERR_ADDR, '0, 8'h00, RESP_SLVERR, 0, 0);
      rows[13] = make_txn(OP_WRITE, 14, ERR_ADDR, 64'h0bad_f00d_0bad_f00d, 8'hff, RESP_SLVERR, 1, 0);
      rows[14] = make_txn(OP_WRITE_W_FIRST, 15, 32'h118, 64'h8899_aabb_ccdd_eeff, 8'hff,
                          RESP_OKAY, 1, 5);
      rows[15] = make_txn(OP_READ, 0, 32'h118, '0, 8'h00, RESP_OKAY, 0, 4);
      rows[16] = make_txn(OP_WRITE_W_FIRST, 1, 32'h118, 64'h0000_1111_2222_3333, 8'h3c,
                          RESP_OKAY, 4, 2);
      rows[17] = make_txn(OP_READ, 2, 32'h118, '0, 8'h00, RESP_OKAY, 0, 0);

      repeat (4) @(posedge bus_clk);
      @(negedge bus_clk);
      reset = 1'b0;

      for (int row = 0; row < NUM_ROWS; row++) begin
         t         = rows[row];
         tag       = $sformatf("row %0d", row);
         log_start = memory_inst.log_count;
         if (t.op == OP_READ)
            send_read(t);
         else
            send_write(t);
         wait_response(t, resp, data);
         check_resp(resp, t.resp, tag);
         check_count(memory_inst.log_count - log_start, t.beats, tag);
         if (t.op == OP_READ) begin
            // An errored read returns the last write beat address twice
            expected = (t.resp == RESP_SLVERR) ? {2{last_beat_addr}} : shadow[t.addr];
            check_data(data, expected, tag);
         end else begin
            derive_beats(t.addr, t.strb, n_beats);
            for (int i = 0; i < n_beats; i++)
               check_beat(memory_inst.log_addr[log_start + i],
                          memory_inst.log_size[log_start + i],
                          beat_addr[i], beat_size[i], tag);
            if (n_beats > 0)
               last_beat_addr = beat_addr[n_beats - 1];
            if (t.resp == RESP_OKAY)
               shadow[t.addr] = merge_bytes(shadow[t.addr], t.data, t.strb);
         end
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== test/tb_ahb_memory.sv ====
// AHB-Lite slave memory model

`timescale 1ns/1ps

module tb_ahb_memory
   import bridge_pkg::*;
#(
   parameter addr_t       ERR_ADDR = 32'h0000_0f00,
   parameter logic [31:0] SEED     = 32'h590d_0229
) (
   input  logic       bus_clk,
   input  logic       reset,
   input  addr_t      haddr,
   input  ahb_size_t  hsize,
   input  ahb_trans_t htrans,
   input  logic       hwrite,
   input  data_t      hwdata,
   output data_t      hrdata,
   output logic       hready,
   output logic       hresp
);

   data_t       mem [0:511];
   addr_t       dp_addr;    // Beat in its data phase
   ahb_size_t   dp_size;
   logic        dp_write;
   logic        dp_err;
   logic        dp_valid;
   logic [1:0]  wait_cnt;
   logic [31:0] rnd;

   // Write beat log, one entry per accepted address phase
   addr_t       log_addr [0:63];
   ahb_size_t   log_size [0:63];
   int          log_count;

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   assign hrdata = mem[dp_addr[11:3]];

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         for (int i = 0; i < 512; i++)
            mem[i] <= {~(32'(i) << 3), 32'(i) << 3};   // Word address with its inverse above
         hready    <= 1'b1;
         hresp     <= 1'b0;
         dp_valid  <= 1'b0;
         wait_cnt  <= 2'd0;
         rnd       <= SEED;
         log_count <= 0;
      end else if (hready) begin
         // Pending data phase completes at this edge
         if (dp_valid && dp_write && !dp_err) begin
            for (int lane = 0; lane < 8; lane++) begin
               if (lane >= int'(dp_addr[2:0]) && lane < int'(dp_addr[2:0]) + (1 << dp_size))
                  mem[dp_addr[11:3]][lane*8 +: 8] <= hwdata[lane*8 +: 8];
            end
         end
         hresp    <= 1'b0;
         dp_valid <= (htrans == HTRANS_NONSEQ);
         if (htrans == HTRANS_NONSEQ) begin
            dp_addr  <= haddr;
            dp_size  <= hsize;
            dp_write <= hwrite;
            dp_err   <= (haddr[31:3] == ERR_ADDR[31:3]);
            rnd      <= xorshift32(rnd);
            if (hwrite) begin
               log_addr[log_count] <= haddr;
               log_size[log_count] <= hsize;
               log_count           <= log_count + 1;
            end
            if (haddr[31:3] == ERR_ADDR[31:3]) begin
               hready <= 1'b0;   // First cycle of the two cycle error
               hresp  <= 1'b1;
            end else if (rnd % 3 != 0) begin
               hready   <= 1'b0;
               wait_cnt <= 2'(rnd % 3) - 2'd1;
            end
         end
      end else if (hresp || wait_cnt == 2'd0) begin
         hready <= 1'b1;
      end else begin
         wait_cnt <= wait_cnt - 2'd1;   // Still waiting
      end
   end

endmodule

// ==== rtl/axi_ahb_bridge.sv ====
// AXI4 to AHB-Lite bridge

`timescale 1ns/1ps

module axi_ahb_bridge
   import bridge_pkg::*;
#(
   parameter int ID_WIDTH = 1
) (
   input  logic                bus_clk,
   input  logic                reset,
   // AXI write address
   input  logic                awvalid,
   output logic                awready,
   input  logic [ID_WIDTH-1:0] awid,
   input  addr_t               awaddr,
   input  ahb_size_t           awsize,
   // AXI write data
   input  logic                wvalid,
   output logic                wready,
   input  data_t               wdata,
   input  strb_t               wstrb,
   input  logic                wlast,
   // AXI write response
   output logic                bvalid,
   input  logic                bready,
   output axi_resp_t           bresp,
   output logic [ID_WIDTH-1:0] bid,
   // AXI read address
   input  logic                arvalid,
   output logic                arready,
   input  logic [ID_WIDTH-1:0] arid,
   input  addr_t               araddr,
   input  ahb_size_t           arsize,
   // AXI read data
   output logic                rvalid,
   input  logic                rready,
   output logic [ID_WIDTH-1:0] rid,
   output data_t               rdata,
   output axi_resp_t           rresp,
   output logic                rlast,
   // AHB-Lite master
   output addr_t               haddr,
   output ahb_size_t           hsize,
   output ahb_trans_t          htrans,
   output logic                hwrite,
   output data_t               hwdata,
   input  data_t               hrdata,
   input  logic                hready,
   input  logic                hresp
);

   logic                aw_held;
   logic                w_held;
   logic                wr_taken;
   logic [ID_WIDTH-1:0] wr_id;
   addr_t               wr_addr;
   ahb_size_t           wr_size;
   data_t               wr_data;
   strb_t               wr_strb;
   logic                cmd_load;
   logic                cmd_write;
   logic                beat_adv;
   logic                last_beat;
   logic                resp_load;
   logic                wr_addr_done;
   logic [ID_WIDTH-1:0] resp_id;
   logic                resp_err;

   assign bresp  = resp_err ? RESP_SLVERR : RESP_OKAY;
   assign rresp  = resp_err ? RESP_SLVERR : RESP_OKAY;
   assign bid    = resp_id;
   assign rid    = resp_id;
   assign rlast  = 1'b1;    // Single beat reads only
   assign hwdata = wr_data;

   bridge_ctrl bridge_ctrl_inst (.*);

   write_capture #(.ID_WIDTH(ID_WIDTH)) write_capture_inst (.*);

   beat_sequencer beat_sequencer_inst (.*);

   resp_capture #(.ID_WIDTH(ID_WIDTH)) resp_capture_inst (.*);

   // Only single beat write bursts are bridged
   a_single_beat_write: assert property (@(posedge bus_clk) disable iff (reset)
      (wvalid && wready) |-> wlast)
      else $error("Write burst longer than one beat");

endmodule

// ==== rtl/bridge_ctrl.sv ====
// Bridge transfer state machine

`timescale 1ns/1ps

module bridge_ctrl
   import bridge_pkg::*;
(
   input  logic       bus_clk,
   input  logic       reset,
   input  logic       aw_held,
   input  logic       w_held,
   input  logic       arvalid,
   input  logic       last_beat,
   input  logic       hready,
   input  logic       hresp,
   input  logic       bready,
   input  logic       rready,
   output logic       arready,
   output logic       wr_taken,
   output logic       cmd_load,
   output logic       cmd_write,
   output logic       beat_adv,
   output ahb_trans_t htrans,
   output logic       hwrite,
   output logic       resp_load,
   output logic       wr_addr_done,
   output logic       bvalid,
   output logic       rvalid
);

   bridge_state_t state;
   bridge_state_t state_nxt;
   logic          wr_ready;     // Both write channels captured
   logic          addr_done;    // Address phase accepted this cycle
   logic          issue_done;   // Final beat already past its address phase

   assign wr_ready  = aw_held & w_held;
   assign arready   = (state == IDLE) & ~wr_ready;
   assign cmd_load  = (state == IDLE) & (wr_ready | arvalid);
   assign cmd_write = wr_ready;   // Writes win over a waiting read
   assign wr_taken  = cmd_load & wr_ready;

   //**************************************************************************
   // Next state and AHB transfer type
   //**************************************************************************

   always_comb begin
      state_nxt = state;
      htrans    = HTRANS_IDLE;
      resp_load = 1'b0;
      case (state)
         IDLE: begin
            if (cmd_load)
               state_nxt = wr_ready ? CMD_WR : CMD_RD;
         end
         CMD_RD: begin
            htrans = HTRANS_NONSEQ;
            if (hready)
               state_nxt = DATA_RD;
         end
         DATA_RD: begin
            if (hready) begin
               resp_load = 1'b1;
               state_nxt = DONE_RD;
            end
         end
         CMD_WR: begin
            htrans = HTRANS_NONSEQ;
            if (hready)
               state_nxt = DATA_WR;
         end
         DATA_WR: begin
            // Next beat overlaps this data phase, dropped once an error shows up
            if (!issue_done && !hresp)
               htrans = HTRANS_NONSEQ;
            if (hready) begin
               resp_load = 1'b1;
               if (htrans == HTRANS_IDLE)
                  state_nxt = DONE_WR;
            end
         end
         DONE_WR: begin
            if (bready)
               state_nxt = IDLE;
         end
         DONE_RD: begin
            if (rready)
               state_nxt = IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   assign hwrite       = (state == CMD_WR) | (state == DATA_WR);
   assign addr_done    = (htrans == HTRANS_NONSEQ) & hready;
   assign wr_addr_done = addr_done & hwrite;
   assign beat_adv     = wr_addr_done & ~last_beat;
   assign bvalid       = (state == DONE_WR);
   assign rvalid       = (state == DONE_RD);

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state      <= IDLE;
         issue_done <= 1'b0;
      end else begin
         state <= state_nxt;
         if (cmd_load)
            issue_done <= 1'b0;
         else if (addr_done)
            issue_done <= last_beat;
      end
   end

   // Two cycle error response from the slave
   a_error_two_cycle: assert property (@(posedge bus_clk) disable iff (reset)
      (hready && hresp) |-> $past(!hready && hresp))
      else $error("AHB error with hready not preceded by error without hready");

endmodule

// ==== rtl/resp_capture.sv ====
// AXI response capture

`timescale 1ns/1ps

module resp_capture
   import bridge_pkg::*;
#(
   parameter int ID_WIDTH = 1
) (
   input  logic                bus_clk,
   input  logic                reset,
   input  logic                cmd_load,
   input  logic                cmd_write,
   input  logic [ID_WIDTH-1:0] wr_id,
   input  logic [ID_WIDTH-1:0] arid,
   input  logic                resp_load,
   input  logic                hresp,
   input  data_t               hrdata,
   input  logic                wr_addr_done,
   input  addr_t               haddr,
   output logic [ID_WIDTH-1:0] resp_id,
   output logic                resp_err,
   output data_t               rdata
);

   addr_t last_wr_addr;   // Address of the latest write beat

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         resp_err     <= 1'b0;
         last_wr_addr <= '0;
      end else begin
         if (cmd_load)
            resp_err <= 1'b0;
         else if (resp_load && hresp)
            resp_err <= 1'b1;   // Sticky over all beats of a command
         if (wr_addr_done)
            last_wr_addr <= haddr;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (cmd_load)
         resp_id <= cmd_write ? wr_id : arid;
      if (resp_load)
         rdata <= hresp ? {2{last_wr_addr}} : hrdata;   // Error data is the write address
   end

endmodule

// ==== rtl/beat_sequencer.sv ====
// AHB beat address and size generation

`timescale 1ns/1ps

module beat_sequencer
   import bridge_pkg::*;
(
   input  logic      bus_clk,
   input  logic      reset,
   input  logic      cmd_load,
   input  logic      cmd_write,
   input  logic      beat_adv,
   input  addr_t     wr_addr,
   input  ahb_size_t wr_size,
   input  strb_t     wr_strb,
   input  addr_t     araddr,
   input  ahb_size_t arsize,
   output addr_t     haddr,
   output ahb_size_t hsize,
   output logic      last_beat
);

   addr_t     cmd_addr;
   ahb_size_t cmd_size;
   strb_t     cmd_strb;
   logic      cmd_wr;
   logic      cmd_aligned;   // Whole command goes out as one beat
   byte_ptr_t byte_ptr;

   logic      load_aligned;
   addr_t     load_addr;
   ahb_size_t load_size;
   strb_t     upper_lanes;

   //**************************************************************************
   // Command decode at load
   //**************************************************************************

   always_comb begin
      load_aligned = ~cmd_write | (wr_size != 3'd3) | strobe_is_aligned(wr_strb);
      if (!cmd_write) begin
         load_addr = araddr;
         load_size = arsize;
      end else if (wr_size != 3'd3) begin
         load_addr = wr_addr;   // Narrow write keeps its own size
         load_size = wr_size;
      end else begin
         load_addr = {wr_addr[31:3], strobe_offset(wr_strb)};
         load_size = strobe_size(wr_strb);
      end
   end

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         cmd_addr    <= '0;
         cmd_size    <= '0;
         cmd_strb    <= '0;
         cmd_wr      <= 1'b0;
         cmd_aligned <= 1'b0;
         byte_ptr    <= '0;
      end else if (cmd_load) begin
         cmd_addr    <= load_addr;
         cmd_size    <= load_size;
         cmd_strb    <= wr_strb;
         cmd_wr      <= cmd_write;
         cmd_aligned <= load_aligned;
         byte_ptr    <= next_byte_lane(wr_strb, 3'd0);
      end else if (beat_adv) begin
         byte_ptr <= next_byte_lane(cmd_strb, byte_ptr + 3'd1);
      end
   end

   // Byte beats walk the set strobe lanes
   assign haddr       = {cmd_addr[31:3], cmd_aligned ? cmd_addr[2:0] : byte_ptr};
   assign hsize       = cmd_aligned ? cmd_size : 3'd0;
   assign upper_lanes = cmd_strb >> byte_ptr;
   assign last_beat   = cmd_aligned | ~cmd_wr | (upper_lanes[7:1] == 7'd0);

   // Holds between commands as well, since outputs only move on load or advance
   a_haddr_aligned: assert property (@(posedge bus_clk) disable iff (reset)
      (haddr & ((32'd1 << hsize) - 32'd1)) == 32'd0)
      else $error("AHB address %h not aligned to size %0d", haddr, hsize);

endmodule

// ==== rtl/write_capture.sv ====
// AXI write channel capture

`timescale 1ns/1ps

module write_capture
   import bridge_pkg::*;
#(
   parameter int ID_WIDTH = 1
) (
   input  logic                bus_clk,
   input  logic                reset,
   input  logic                awvalid,
   input  logic [ID_WIDTH-1:0] awid,
   input  addr_t               awaddr,
   input  ahb_size_t           awsize,
   input  logic                wvalid,
   input  data_t               wdata,
   input  strb_t               wstrb,
   input  logic                wr_taken,
   output logic                awready,
   output logic                wready,
   output logic                aw_held,
   output logic                w_held,
   output logic [ID_WIDTH-1:0] wr_id,
   output addr_t               wr_addr,
   output ahb_size_t           wr_size,
   output data_t               wr_data,
   output strb_t               wr_strb
);

   logic  aw_take;
   logic  w_take;
   data_t w_data_q;   // Held until the command is taken

   assign awready = ~aw_held;
   assign wready  = ~w_held;
   assign aw_take = awvalid & awready;
   assign w_take  = wvalid & wready;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else if (wr_taken) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else begin
         if (aw_take)
            aw_held <= 1'b1;
         if (w_take)
            w_held <= 1'b1;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (aw_take) begin
         wr_id   <= awid;
         wr_addr <= awaddr;
         wr_size <= awsize;
      end
      if (w_take) begin
         w_data_q <= wdata;
         wr_strb  <= wstrb;
      end
      // Write data stays put for AHB while the next write is captured
      if (wr_taken)
         wr_data <= w_data_q;
   end

   a_taken_when_held: assert property (@(posedge bus_clk) disable iff (reset)
      wr_taken |-> (aw_held && w_held))
      else $error("Write taken before both channels were captured");

endmodule

// ==== rtl/bridge_pkg.sv ====
// AXI to AHB bridge shared definitions

package bridge_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;
   typedef logic [2:0]  byte_ptr_t;
   typedef logic [2:0]  ahb_size_t;
   typedef logic [1:0]  axi_resp_t;

   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_NONSEQ = 2'b10
   } ahb_trans_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      CMD_RD  = 3'd1,
      DATA_RD = 3'd2,
      CMD_WR  = 3'd3,
      DATA_WR = 3'd4,
      DONE_WR = 3'd5,
      DONE_RD = 3'd6
   } bridge_state_t;

   //**************************************************************************
   // Strobe decoding
   //**************************************************************************

   // Patterns that fit one naturally aligned AHB beat
   function automatic logic strobe_is_aligned(strb_t strb);
      return strb inside {8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0};
   endfunction

   function automatic ahb_size_t strobe_size(strb_t strb);
      ahb_size_t size;
      case (strb)
         8'hff:        size = 3'd3;
         8'h0f, 8'hf0: size = 3'd2;
         default:      size = 3'd1;   // Halfword patterns
      endcase
      return size;
   endfunction

   function automatic byte_ptr_t strobe_offset(strb_t strb);
      byte_ptr_t offset;
      case (strb)
         8'h0c:        offset = 3'd2;
         8'hf0, 8'h30: offset = 3'd4;
         8'hc0:        offset = 3'd6;
         default:      offset = 3'd0;
      endcase
      return offset;
   endfunction

   // Lowest set lane at or above start, start itself if none
   function automatic byte_ptr_t next_byte_lane(strb_t strb, byte_ptr_t start);
      byte_ptr_t lane;
      lane = start;
      for (int i = 7; i >= 0; i--) begin
         if (strb[i] && (i >= int'(start)))
            lane = byte_ptr_t'(i);
      end
      return lane;
   endfunction

endpackage
